/* source/ahb_pkg.sv */
// AHB-lite bus types
package ahb_pkg;

   // ----------------------------------------
   // Transfer and response encodings
   // ----------------------------------------

   // Transfer type on htrans
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_t;

   // AHB-lite slave response, one bit wide
   typedef enum logic {
      OKAY  = 1'b0,
      ERROR = 1'b1
   } hresp_t;

   // ----------------------------------------
   // Bundled bus directions
   // ----------------------------------------

   // Master to slave, address phase plus write data
   typedef struct packed {
      logic        hsel;
      logic [31:0] haddr;
      htrans_t     htrans;
      logic        hwrite;
      logic [31:0] hwdata;
      logic        hready_in;
   } ahb_req_t;

   // Slave to master
   typedef struct packed {
      logic [31:0] hrdata;
      logic        hready;
      hresp_t      hresp;
   } ahb_rsp_t;

endpackage

/* source/apb_pkg.sv */
// APB bus types and slave map
package apb_pkg;

   // ----------------------------------------
   // Slave map
   // ----------------------------------------

   // Slave 0 is the ALUT, slaves 1 to 4 are MAC 0 to 3
   localparam int N_SLAVES = 5;

   // External MAC register blocks
   localparam int N_MACS = N_SLAVES - 1;

   // Index of the addressed slave
   typedef logic [2:0] slave_idx_t;

   // ALUT slot
   localparam slave_idx_t ALUT_IDX = 3'd0;

   // ----------------------------------------
   // Bundled bus directions
   // ----------------------------------------

   // Bridge to slaves
   // psel is the bus-wide select, slave picks the target
   typedef struct packed {
      logic [31:0] paddr;
      logic        pwrite;
      logic [31:0] pwdata;
      logic        psel;
      logic        penable;
      slave_idx_t  slave;
   } apb_req_t;

   // Slave to bridge
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
   } apb_rsp_t;

endpackage

/* source/ahb_apb_bridge.sv */
// AHB-lite to APB bridge
`timescale 1ns/10ps

module ahb_apb_bridge (
   input  logic                hclk,
   input  logic                arst_n,
   // AHB-lite slave side
   input  ahb_pkg::ahb_req_t   ahb_req,
   output ahb_pkg::ahb_rsp_t   ahb_rsp,
   // From the address decoder
   input  apb_pkg::slave_idx_t slave,
   input  logic                miss,
   // APB master side
   output apb_pkg::apb_req_t   apb_req,
   input  apb_pkg::apb_rsp_t   apb_rsp
);

   import ahb_pkg::*;
   import apb_pkg::*;

   // Bridge states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CAPTURE,
      ST_SETUP,
      ST_ACCESS,
      ST_DONE,
      ST_ERR1,
      ST_ERR2
   } state_t;

   state_t      state_q;
   state_t      state_d;

   // Payload held for the APB transfer
   logic [31:0] haddr_q;
   logic        hwrite_q;
   slave_idx_t  slave_q;
   logic [31:0] hwdata_q;
   logic [31:0] prdata_q;

   logic        hready_int;
   logic        trans_active;
   logic        accept;
   logic        access_done;

   // ----------------------------------------
   // Transfer acceptance
   // ----------------------------------------

   // Data phase can end only in these states
   assign hready_int = (state_q == ST_IDLE) || (state_q == ST_DONE) ||
                       (state_q == ST_ERR2);

   // NONSEQ and SEQ only, IDLE and BUSY pass through
   assign trans_active = (ahb_req.htrans == NONSEQ) || (ahb_req.htrans == SEQ);

   assign accept = ahb_req.hsel && trans_active && ahb_req.hready_in && hready_int;

   // Last access cycle of the APB transfer
   assign access_done = (state_q == ST_ACCESS) && apb_rsp.pready;

   // ----------------------------------------
   // State machine
   // ----------------------------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         // Waiting states, each may take a new transfer
         ST_IDLE, ST_DONE, ST_ERR2: begin
            if (accept) begin
               state_d = miss ? ST_ERR1 : ST_CAPTURE;
            end else begin
               state_d = ST_IDLE;
            end
         end
         ST_CAPTURE: state_d = ST_SETUP;
         ST_SETUP:   state_d = ST_ACCESS;
         // Stay while the slave holds pready low
         ST_ACCESS: begin
            if (apb_rsp.pready) begin
               state_d = ST_DONE;
            end
         end
         // Second error cycle always follows the first
         ST_ERR1:    state_d = ST_ERR2;
         default:    state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ----------------------------------------
   // Address, data and read capture
   // ----------------------------------------

   always_ff @(posedge hclk) begin
      // Address phase
      if (accept) begin
         haddr_q  <= ahb_req.haddr;
         hwrite_q <= ahb_req.hwrite;
         slave_q  <= slave;
      end
      // Write data arrives one cycle after the address
      if (state_q == ST_CAPTURE) begin
         hwdata_q <= ahb_req.hwdata;
      end
      // Read data from the completing access
      if (access_done) begin
         prdata_q <= apb_rsp.prdata;
      end
   end

   // ----------------------------------------
   // Outputs
   // ----------------------------------------

   // APB request held steady through setup and access
   always_comb begin
      apb_req.paddr   = haddr_q;
      apb_req.pwrite  = hwrite_q;
      apb_req.pwdata  = hwdata_q;
      apb_req.slave   = slave_q;
      // Misses go to the error states and never reach these
      apb_req.psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
      apb_req.penable = (state_q == ST_ACCESS);
   end

   // AHB response
   always_comb begin
      ahb_rsp.hrdata = prdata_q;
      ahb_rsp.hready = hready_int;
      ahb_rsp.hresp  = ((state_q == ST_ERR1) || (state_q == ST_ERR2)) ? ERROR : OKAY;
   end

endmodule

/* source/apb_addr_decoder.sv */
// APB window address decoder
`timescale 1ns/10ps

module apb_addr_decoder #(
   parameter logic [31:0] base_addr   = 32'h00A00000,
   parameter int unsigned window_bits = 16
) (
   input  logic [31:0]         haddr,
   output apb_pkg::slave_idx_t slave,
   output logic                miss
);

   import apb_pkg::*;

   // Offset from the first window
   logic [31:0] offset;

   // Window number, one window per slave
   logic [31:0] window;

   logic        below_base;
   logic        above_top;

   // ----------------------------------------
   // Window lookup
   // ----------------------------------------

   always_comb begin
      below_base = haddr < base_addr;
      offset     = haddr - base_addr;
      window     = offset >> window_bits;
      // Slot 5 and beyond are not mapped
      above_top  = window >= 32'(N_SLAVES);
   end

   // ----------------------------------------
   // Result
   // ----------------------------------------

   assign miss = below_base || above_top;

   // Index forced to zero on a miss, bridge ignores it then
   always_comb begin
      if (miss) begin
         slave = '0;
      end else begin
         slave = slave_idx_t'(window[$bits(slave_idx_t)-1:0]);
      end
   end

endmodule

/* source/alut_regs.sv */
// Address lookup table registers
`timescale 1ns/10ps

module alut_regs #(
   parameter int alut_entries = 8
) (
   input  logic              hclk,
   input  logic              arst_n,
   input  logic              psel,
   input  apb_pkg::apb_req_t apb_req,
   output apb_pkg::apb_rsp_t apb_rsp
);

   // Register offsets within the window
   localparam logic [6:0] OFS_KEY_LO = 7'h00;
   localparam logic [6:0] OFS_KEY_HI = 7'h04;
   localparam logic [6:0] OFS_CMD    = 7'h08;
   localparam logic [6:0] OFS_RESULT = 7'h0C;
   localparam logic [6:0] OFS_COUNT  = 7'h10;

   localparam int CNT_W = $clog2(alut_entries + 1);

   // One table entry
   typedef struct packed {
      logic        valid;
      logic [1:0]  port;
      logic [47:0] mac;
   } alut_entry_t;

   alut_entry_t table_q [alut_entries];

   logic [31:0]      key_lo_q;
   logic [15:0]      key_hi_q;
   logic [47:0]      key;

   logic             wr_en;
   logic [2:0]       cmd_idx;
   logic             hit;
   logic [1:0]       hit_port;
   logic [CNT_W-1:0] valid_cnt;

   // ----------------------------------------
   // APB writes
   // ----------------------------------------

   // Access cycle of a write, always zero wait
   assign wr_en   = psel && apb_req.penable && apb_req.pwrite;
   assign cmd_idx = apb_req.pwdata[2:0];
   assign key     = {key_hi_q, key_lo_q};

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         key_lo_q <= '0;
         key_hi_q <= '0;
         for (int i = 0; i < alut_entries; i++) begin
            table_q[i] <= '0;
         end
      end else if (wr_en) begin
         case (apb_req.paddr[6:0])
            OFS_KEY_LO: key_lo_q <= apb_req.pwdata;
            OFS_KEY_HI: key_hi_q <= apb_req.pwdata[15:0];
            OFS_CMD: begin
               // Out of range index is dropped
               if (32'(cmd_idx) < alut_entries) begin
                  if (apb_req.pwdata[8]) begin
                     table_q[cmd_idx] <= '0;
                  end else begin
                     table_q[cmd_idx].valid <= 1'b1;
                     table_q[cmd_idx].port  <= apb_req.pwdata[5:4];
                     table_q[cmd_idx].mac   <= key;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   // ----------------------------------------
   // Lookup and count
   // ----------------------------------------

   // Scan from the top so the lowest index wins
   always_comb begin
      hit       = 1'b0;
      hit_port  = '0;
      valid_cnt = '0;
      for (int i = alut_entries - 1; i >= 0; i--) begin
         if (table_q[i].valid && (table_q[i].mac == key)) begin
            hit      = 1'b1;
            hit_port = table_q[i].port;
         end
         valid_cnt = valid_cnt + CNT_W'(table_q[i].valid);
      end
   end

   // ----------------------------------------
   // APB reads
   // ----------------------------------------

   always_comb begin
      apb_rsp.pready = 1'b1;
      case (apb_req.paddr[6:0])
         OFS_KEY_LO: apb_rsp.prdata = key_lo_q;
         OFS_KEY_HI: apb_rsp.prdata = {16'h0, key_hi_q};
         OFS_RESULT: apb_rsp.prdata = {hit, 29'h0, hit_port};
         OFS_COUNT:  apb_rsp.prdata = 32'(valid_cnt);
         // Write-only command register and unused offsets
         default:    apb_rsp.prdata = '0;
      endcase
   end

endmodule

/* source/apb_slave_mux.sv */
// APB select fan-out and response mux
`timescale 1ns/10ps

module apb_slave_mux (
   input  apb_pkg::apb_req_t                   apb_req,
   output logic                                psel_alut,
   output logic [apb_pkg::N_MACS-1:0]          psel_mac,
   input  apb_pkg::apb_rsp_t                   alut_rsp,
   input  apb_pkg::apb_rsp_t [apb_pkg::N_MACS-1:0] mac_rsp,
   output apb_pkg::apb_rsp_t                   apb_rsp
);

   import apb_pkg::*;

   logic     [N_SLAVES-1:0] sel_onehot;
   apb_rsp_t [N_SLAVES-1:0] slave_rsp;

   // ----------------------------------------
   // Select fan-out
   // ----------------------------------------

   // One-hot select, qualified by the bus-wide psel
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         sel_onehot[i] = apb_req.psel && (apb_req.slave == slave_idx_t'(i));
      end
   end

   assign psel_alut = sel_onehot[ALUT_IDX];
   assign psel_mac  = sel_onehot[N_SLAVES-1:1];

   // ----------------------------------------
   // Response mux
   // ----------------------------------------

   // ALUT in slot 0, MACs above it
   assign slave_rsp = {mac_rsp, alut_rsp};

   // Unused indices answer ready with zero data
   always_comb begin
      apb_rsp = '{prdata: '0, pready: 1'b1};
      if (32'(apb_req.slave) < N_SLAVES) begin
         apb_rsp = slave_rsp[apb_req.slave];
      end
   end

endmodule

/* source/apb_subsystem.sv */
// APB peripheral subsystem top level
`timescale 1ns/10ps

module apb_subsystem #(
   parameter logic [31:0] base_addr    = 32'h00A00000,
   parameter int unsigned window_bits  = 16,
   parameter int          alut_entries = 8
) (
   input  logic                                    hclk,
   input  logic                                    arst_n,
   // AHB-lite port
   input  ahb_pkg::ahb_req_t                       ahb_req,
   output ahb_pkg::ahb_rsp_t                       ahb_rsp,
   // Shared APB request to the MACs
   output apb_pkg::apb_req_t                       apb_req,
   output logic [apb_pkg::N_MACS-1:0]              psel_mac,
   input  apb_pkg::apb_rsp_t [apb_pkg::N_MACS-1:0] mac_rsp
);

   import apb_pkg::*;

   // ----------------------------------------
   // Internal wires
   // ----------------------------------------

   // Decoder to bridge
   slave_idx_t slave_idx;
   logic       addr_miss;

   // ALUT select and response
   logic       psel_alut;
   apb_rsp_t   alut_rsp;

   // Combined response back to the bridge
   apb_rsp_t   mux_rsp;

   // ----------------------------------------
   // Instances
   // ----------------------------------------

   // Address phase decode
   apb_addr_decoder #(
      .base_addr   (base_addr),
      .window_bits (window_bits)
   ) apb_addr_decoder_i (
      .haddr (ahb_req.haddr),
      .slave (slave_idx),
      .miss  (addr_miss)
   );

   // AHB to APB protocol conversion
   ahb_apb_bridge ahb_apb_bridge_i (
      .hclk    (hclk),
      .arst_n  (arst_n),
      .ahb_req (ahb_req),
      .ahb_rsp (ahb_rsp),
      .slave   (slave_idx),
      .miss    (addr_miss),
      .apb_req (apb_req),
      .apb_rsp (mux_rsp)
   );

   // Select fan-out and response combine
   apb_slave_mux apb_slave_mux_i (
      .apb_req   (apb_req),
      .psel_alut (psel_alut),
      .psel_mac  (psel_mac),
      .alut_rsp  (alut_rsp),
      .mac_rsp   (mac_rsp),
      .apb_rsp   (mux_rsp)
   );

   // Slave 0, the lookup table
   alut_regs #(
      .alut_entries (alut_entries)
   ) alut_regs_i (
      .hclk    (hclk),
      .arst_n  (arst_n),
      .psel    (psel_alut),
      .apb_req (apb_req),
      .apb_rsp (alut_rsp)
   );

endmodule

/* testbench/tb_apb_subsystem.sv */
// APB subsystem testbench
`timescale 1ns/10ps

module tb_apb_subsystem;

   import ahb_pkg::*;
   import apb_pkg::*;

   // DUT configuration
   localparam logic [31:0] base_addr    = 32'h00A00000;
   localparam int          window_bits  = 16;
   localparam int          alut_entries = 8;

   // Run limit, about ten times the length of all tests
   localparam int          max_cycles   = 4000;

   logic           hclk;
   logic           arst_n;
   ahb_req_t       ahb_req;
   ahb_rsp_t       ahb_rsp;
   apb_req_t       apb_req;
   logic [3:0]     psel_mac;
   apb_rsp_t [3:0] mac_rsp;

   // ----------------------------------------
   // MAC model state
   // ----------------------------------------

   // 64 words per MAC, indexed by paddr[7:2]
   logic [31:0] mac_mem [4][64];
   int          wait_left [4];
   logic        in_access [4];
   logic [31:0] lcg_state;
   logic        random_waits;

   // Request as seen in setup and in the completing access
   apb_req_t    setup_req [4];
   logic [3:0]  setup_psel [4];
   apb_req_t    seen_req [4];
   logic [3:0]  seen_psel [4];

   // Set when an access cycle differs from its setup
   logic        req_moved [4];
   apb_req_t    held_req;

   // Last AHB transfer
   ahb_rsp_t    last_rsp;
   ahb_rsp_t    first_rsp;
   int          last_cycles;
   logic        last_saw_psel;

   int          mismatch_cnt;
   int          other_cnt;
   int          cycle_cnt;

   apb_subsystem #(
      .base_addr    (base_addr),
      .window_bits  (window_bits),
      .alut_entries (alut_entries)
   ) apb_subsystem_i (
      .hclk     (hclk),
      .arst_n   (arst_n),
      .ahb_req  (ahb_req),
      .ahb_rsp  (ahb_rsp),
      .apb_req  (apb_req),
      .psel_mac (psel_mac),
      .mac_rsp  (mac_rsp)
   );

   initial begin
      hclk = 1'b0;
      forever #20 hclk = ~hclk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Slot 0 is the ALUT, slot n+1 is MAC n
   function automatic logic [31:0] window_addr(input int slot, input logic [7:0] offset);
      return base_addr + (32'(slot) << window_bits) + {24'h0, offset};
   endfunction

   // Response that closes a data phase
   function automatic ahb_rsp_t end_rsp(input logic [31:0] data, input hresp_t resp);
      ahb_rsp_t rsp;
      rsp.hrdata = data;
      rsp.hready = 1'b1;
      rsp.hresp  = resp;
      return rsp;
   endfunction

   // Setup cycle request for MAC m, slave index m+1
   function automatic apb_req_t expected_setup(input int m, input logic [31:0] addr,
                                               input logic write, input logic [31:0] data);
      apb_req_t req;
      req        = '0;
      req.paddr  = addr;
      req.pwrite = write;
      req.pwdata = data;
      req.psel   = 1'b1;
      req.slave  = slave_idx_t'(m + 1);
      return req;
   endfunction

   // ----------------------------------------
   // MAC models, driven 2 ns after the edge
   // ----------------------------------------

   initial begin
      lcg_state = 32'h4661177e;
      for (int m = 0; m < 4; m++) begin
         wait_left[m]      = 0;
         in_access[m]      = 1'b0;
         req_moved[m]      = 1'b0;
         mac_rsp[m].pready = 1'b1;
         mac_rsp[m].prdata = '0;
         for (int w = 0; w < 64; w++) begin
            mac_mem[m][w] = 32'hA5000000 ^ (32'(m) << 12) ^ (32'(w) * 32'h00010101);
         end
      end
      forever begin
         @(posedge hclk);
         #2;
         for (int m = 0; m < 4; m++) begin
            if (psel_mac[m] && !in_access[m]) begin
               // Setup cycle, pick the wait count
               lcg_state         = lcg_next(lcg_state);
               wait_left[m]      = random_waits ? int'(lcg_state[31:30]) : 0;
               mac_rsp[m].pready = 1'b0;
               setup_req[m]      = apb_req;
               setup_psel[m]     = psel_mac;
               req_moved[m]      = 1'b0;
               in_access[m]      = 1'b1;
            end else if (psel_mac[m]) begin
               // Access cycle, setup request with penable high
               held_req         = setup_req[m];
               held_req.penable = 1'b1;
               if ((apb_req !== held_req) || (psel_mac !== setup_psel[m])) begin
                  req_moved[m] = 1'b1;
               end
               mac_rsp[m].pready = (wait_left[m] == 0);
               mac_rsp[m].prdata = mac_mem[m][apb_req.paddr[7:2]];
               if (wait_left[m] != 0) begin
                  wait_left[m] = wait_left[m] - 1;
               end else begin
                  // Completes at the next edge
                  in_access[m] = 1'b0;
                  seen_req[m]  = apb_req;
                  seen_psel[m] = psel_mac;
                  if (apb_req.pwrite) begin
                     mac_mem[m][apb_req.paddr[7:2]] = apb_req.pwdata;
                  end
               end
            end else begin
               mac_rsp[m].pready = 1'b1;
               in_access[m]      = 1'b0;
            end
         end
      end
   end

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
      if (got !== exp) begin
         $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
         mismatch_cnt++;
      end
   endtask

   task automatic check_rsp(input string what, input ahb_rsp_t exp, input logic with_data,
                            input ahb_rsp_t got);
      check_value({what, " hready"}, {31'h0, exp.hready}, {31'h0, got.hready});
      check_value({what, " hresp"}, {31'h0, exp.hresp}, {31'h0, got.hresp});
      if (with_data) begin
         check_value({what, " hrdata"}, exp.hrdata, got.hrdata);
      end
   endtask

   // APB fields at the MAC port, pwdata only for writes
   task automatic check_apb(input string what, input apb_req_t exp, input logic [3:0] exp_psel,
                            input apb_req_t got, input logic [3:0] got_psel);
      check_value({what, " paddr"}, exp.paddr, got.paddr);
      check_value({what, " pwrite"}, {31'h0, exp.pwrite}, {31'h0, got.pwrite});
      if (exp.pwrite) begin
         check_value({what, " pwdata"}, exp.pwdata, got.pwdata);
      end
      check_value({what, " psel"}, {31'h0, exp.psel}, {31'h0, got.psel});
      check_value({what, " penable"}, {31'h0, exp.penable}, {31'h0, got.penable});
      check_value({what, " slave"}, {29'h0, exp.slave}, {29'h0, got.slave});
      check_value({what, " psel_mac"}, {28'h0, exp_psel}, {28'h0, got_psel});
   endtask

   // Setup and completing access at MAC m, no change in between
   task automatic check_held(input string what, input int m, input apb_req_t exp);
      apb_req_t exp_access;
      exp_access         = exp;
      exp_access.penable = 1'b1;
      check_apb({what, " setup"}, exp, 4'b0001 << m, setup_req[m], setup_psel[m]);
      check_apb({what, " access"}, exp_access, 4'b0001 << m, seen_req[m], seen_psel[m]);
      if (req_moved[m]) begin
         $display("error: %s request changed while MAC %0d held the access", what, m);
         other_cnt++;
      end
   endtask

   // ----------------------------------------
   // AHB master
   // ----------------------------------------

   task automatic ahb_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata);
      logic done;
      ahb_req.hsel   = 1'b1;
      ahb_req.haddr  = addr;
      ahb_req.htrans = NONSEQ;
      ahb_req.hwrite = write;
      // Address phase holds until hready is high
      @(negedge hclk);
      while (!ahb_rsp.hready) begin
         @(negedge hclk);
      end
      @(posedge hclk);
      #2;
      ahb_req.hsel   = 1'b0;
      ahb_req.htrans = IDLE;
      ahb_req.hwdata = wdata;
      last_cycles    = 0;
      last_saw_psel  = 1'b0;
      done           = 1'b0;
      // Data phase, one sample per cycle
      while (!done) begin
         @(negedge hclk);
         last_cycles++;
         if (last_cycles == 1) begin
            first_rsp = ahb_rsp;
         end
         last_saw_psel = last_saw_psel | apb_req.psel | (psel_mac != 4'h0);
         last_rsp      = ahb_rsp;
         done          = ahb_rsp.hready;
         @(posedge hclk);
      end
      #2;
   endtask

   task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
      ahb_transfer(1'b1, addr, data);
   endtask

   task automatic ahb_read(input logic [31:0] addr);
      ahb_transfer(1'b0, addr, 32'h0);
   endtask

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------

   task automatic reset_state();
      @(negedge hclk);
      check_rsp("reset", end_rsp('0, OKAY), 1'b0, ahb_rsp);
      check_value("reset psel_mac", 32'h0, {28'h0, psel_mac});
      check_value("reset psel and penable", 32'h0, {30'h0, apb_req.psel, apb_req.penable});
      @(posedge hclk);
      #2;
   endtask

   task automatic mac_access();
      logic [31:0] data [4];
      logic [31:0] addr;
      for (int m = 0; m < 4; m++) begin
         data[m] = 32'hC0DE0000 + 32'(m) * 32'h01010011;
         addr    = window_addr(m + 1, 8'h20);
         ahb_write(addr, data[m]);
         check_rsp("mac write", end_rsp('0, OKAY), 1'b0, last_rsp);
         check_held("mac write", m, expected_setup(m, addr, 1'b1, data[m]));
         if (m == 0) begin
            check_value("mac 0 write cycles", 32'd4, 32'(last_cycles));
         end
      end
      for (int m = 0; m < 4; m++) begin
         addr = window_addr(m + 1, 8'h20);
         ahb_read(addr);
         check_rsp("mac read", end_rsp(data[m], OKAY), 1'b1, last_rsp);
         check_held("mac read", m, expected_setup(m, addr, 1'b0, 32'h0));
         if (m == 0) begin
            check_value("mac 0 read cycles", 32'd4, 32'(last_cycles));
         end
      end
   endtask

   task automatic back_pressure();
      logic [31:0] addr;
      logic [31:0] data;
      int          m;
      int          longest;
      longest      = 0;
      random_waits = 1'b1;
      for (int i = 0; i < 12; i++) begin
         m    = i % 4;
         addr = window_addr(m + 1, 8'h40 + 8'(4 * i));
         data = 32'h5EED0000 ^ (32'(i) * 32'h00130507);
         ahb_write(addr, data);
         longest = (last_cycles > longest) ? last_cycles : longest;
         check_held("held write", m, expected_setup(m, addr, 1'b1, data));
         ahb_read(addr);
         longest = (last_cycles > longest) ? last_cycles : longest;
         check_rsp("held read", end_rsp(data, OKAY), 1'b1, last_rsp);
         check_held("held read", m, expected_setup(m, addr, 1'b0, 32'h0));
      end
      random_waits = 1'b0;
      if (longest <= 4) begin
         $display("error: no MAC wait state was inserted during the back-pressure test");
         other_cnt++;
      end
   endtask

   task automatic set_key(input logic [47:0] mac);
      ahb_write(window_addr(0, 8'h00), mac[31:0]);
      ahb_write(window_addr(0, 8'h04), {16'h0, mac[47:32]});
   endtask

   task automatic add_entry(input int idx, input logic [47:0] mac, input logic [1:0] port);
      set_key(mac);
      ahb_write(window_addr(0, 8'h08), 32'(idx) | {26'h0, port, 4'h0});
   endtask

   task automatic clear_entry(input int idx);
      ahb_write(window_addr(0, 8'h08), 32'h100 | 32'(idx));
   endtask

   task automatic expect_lookup(input logic [47:0] mac, input logic hit, input logic [1:0] port);
      set_key(mac);
      ahb_read(window_addr(0, 8'h0C));
      check_rsp("lookup", end_rsp({hit, 29'h0, port}, OKAY), 1'b1, last_rsp);
   endtask

   task automatic expect_count(input int n);
      ahb_read(window_addr(0, 8'h10));
      check_rsp("count", end_rsp(32'(n), OKAY), 1'b1, last_rsp);
   endtask

   task automatic alut_table();
      logic [47:0] mac_a;
      logic [47:0] mac_b;
      logic [47:0] mac_c;
      mac_a = 48'h0011_2233_4455;
      mac_b = 48'h00AA_BBCC_DDEE;
      mac_c = 48'h0102_0304_0506;
      expect_count(0);
      add_entry(0, mac_a, 2'd1);
      expect_count(1);
      add_entry(3, mac_b, 2'd2);
      expect_count(2);
      add_entry(7, mac_c, 2'd3);
      expect_count(3);
      expect_lookup(mac_a, 1'b1, 2'd1);
      expect_lookup(mac_b, 1'b1, 2'd2);
      expect_lookup(mac_c, 1'b1, 2'd3);
      expect_lookup(48'h0000_DEAD_BEEF, 1'b0, 2'd0);
      // Same address in slot 5, slot 3 wins
      add_entry(5, mac_b, 2'd0);
      expect_count(4);
      expect_lookup(mac_b, 1'b1, 2'd2);
      clear_entry(3);
      expect_count(3);
      expect_lookup(mac_b, 1'b1, 2'd0);
      clear_entry(5);
      expect_count(2);
      expect_lookup(mac_b, 1'b0, 2'd0);
   endtask

   task automatic unmapped_access();
      logic [31:0] addrs [2];
      ahb_rsp_t    exp_first;
      addrs[0]         = window_addr(5, 8'h00);
      addrs[1]         = base_addr - 32'h4;
      exp_first.hrdata = '0;
      exp_first.hready = 1'b0;
      exp_first.hresp  = ERROR;
      for (int i = 0; i < 2; i++) begin
         ahb_transfer(i == 0, addrs[i], 32'hBAD00000);
         check_rsp("error first cycle", exp_first, 1'b0, first_rsp);
         check_rsp("error last cycle", end_rsp('0, ERROR), 1'b0, last_rsp);
         check_value("error cycles", 32'd2, 32'(last_cycles));
         if (last_saw_psel) begin
            $display("error: select raised for unmapped address %h", addrs[i]);
            other_cnt++;
         end
      end
   endtask

   // IDLE then BUSY, each zero wait and no APB activity
   task automatic idle_transfers();
      ahb_req.hsel   = 1'b1;
      ahb_req.haddr  = window_addr(1, 8'h00);
      ahb_req.hwrite = 1'b1;
      // Each sample shows the response to the cycle before it
      for (int i = 0; i < 5; i++) begin
         if (i < 4) begin
            ahb_req.htrans = (i < 2) ? IDLE : BUSY;
         end else begin
            ahb_req.hsel   = 1'b0;
            ahb_req.htrans = IDLE;
         end
         @(negedge hclk);
         check_rsp("idle", end_rsp('0, OKAY), 1'b0, ahb_rsp);
         check_value("idle psel and psel_mac", 32'h0, {27'h0, apb_req.psel, psel_mac});
         @(posedge hclk);
         #2;
      end
   endtask

   // ----------------------------------------
   // Test sequence and watchdog
   // ----------------------------------------

   initial begin
      mismatch_cnt      = 0;
      other_cnt         = 0;
      random_waits      = 1'b0;
      ahb_req           = '0;
      ahb_req.htrans    = IDLE;
      ahb_req.hready_in = 1'b1;
      arst_n            = 1'b0;
      repeat (3) @(posedge hclk);
      #2;
      arst_n = 1'b1;
      reset_state();
      mac_access();
      back_pressure();
      alut_table();
      unmapped_access();
      idle_transfers();
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt + other_cnt == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < max_cycles) begin
         @(posedge hclk);
         cycle_cnt++;
      end
      $display("error: tests still running after %0d cycles", max_cycles);
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* all.f */
source/ahb_pkg.sv
source/apb_pkg.sv
source/ahb_apb_bridge.sv
source/apb_addr_decoder.sv
source/alut_regs.sv
source/apb_slave_mux.sv
source/apb_subsystem.sv
testbench/tb_apb_subsystem.sv

/* Makefile */
# Verilator build and run of the APB subsystem testbench

obj_dir/Vtb_apb_subsystem: all.f $(wildcard source/*.sv) $(wildcard testbench/*.sv)
	verilator --binary -f all.f --top-module tb_apb_subsystem

# Fails unless the pass line is in the output
run: obj_dir/Vtb_apb_subsystem
	@out=$$(./obj_dir/Vtb_apb_subsystem); echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

.PHONY: run clean
